// ==== design/lsq_defs.svh ====
`ifndef LSQ_DEFS_SVH
`define LSQ_DEFS_SVH

// address layout
`define ADDR_W 32
`define BANK_W 5
`define LOW_W 2
`define BEN_W 4

// access size code
`define SZ_W 3

// store data before and after alignment
`define SDATA_W 128
`define WDATA_W 160

// store queue
`define STQ_DEPTH 16
`define STQ_PTR_W 4

// stall when fewer free entries than this
`define STQ_STALL_MARGIN 4

`endif

// ==== design/mem_access_pkg.sv ====
`default_nettype none

`include "lsq_defs.svh"

package mem_access_pkg;

  // tag, then bank, then byte within bank
  typedef struct packed {
    logic [`ADDR_W-`BANK_W-`LOW_W-1:0] tag;
    logic [`BANK_W-1:0]                bank;
    logic [`LOW_W-1:0]                 low;
  } st_addr_fields_t;

  // same 32 bits, flat or split into cache fields
  typedef union packed {
    logic [`ADDR_W-1:0] word;
    st_addr_fields_t    f;
  } st_addr_u;

  // byte count is 2**code, codes 5..7 unused
  typedef enum logic [`SZ_W-1:0] {
    SZ_1  = 3'd0,
    SZ_2  = 3'd1,
    SZ_4  = 3'd2,
    SZ_8  = 3'd3,
    SZ_16 = 3'd4
  } access_sz_e;

endpackage

`default_nettype wire

// ==== design/store_port_pkg.sv ====
`default_nettype none

`include "lsq_defs.svh"

package store_port_pkg;

  // one store as held in the queue, value in the low bytes
  typedef struct packed {
    mem_access_pkg::st_addr_u   addr;
    mem_access_pkg::access_sz_e sz;
    logic [`SDATA_W-1:0]        data;
  } st_req_t;

  // write-request stage, one per lane
  typedef struct packed {
    logic    en;
    st_req_t req;
  } st_stage_t;

  // write request toward the data cache
  typedef struct packed {
    logic                       en;
    mem_access_pkg::st_addr_u   adata;
    mem_access_pkg::access_sz_e sz;
    logic [`BANK_W-1:0]         bank1;
    logic [`BEN_W-1:0]          bgn_ben;
    logic [`BEN_W-1:0]          end_ben;
    logic [`WDATA_W-1:0]        data;
  } st_wreq_t;

endpackage

`default_nettype wire

// ==== design/store_queue.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "lsq_defs.svh"

module store_queue (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    except,
  input  store_port_pkg::st_req_t enq0,
  input  store_port_pkg::st_req_t enq1,
  input  logic                    enq0_en,
  input  logic                    enq1_en,
  input  logic [1:0]              ret_cnt,
  input  logic                    hold,
  output store_port_pkg::st_req_t drain0,
  output store_port_pkg::st_req_t drain1,
  output logic [1:0]              drain_en,
  output logic                    stq_stall
);

  localparam int PTR_W = `STQ_PTR_W;
  localparam int CNT_W = `STQ_PTR_W + 1;
  localparam int STALL_LVL = `STQ_DEPTH - `STQ_STALL_MARGIN;

  store_port_pkg::st_req_t mem [`STQ_DEPTH];

  // head .. commit-1 committed, commit .. tail-1 waiting for retire
  logic [PTR_W-1:0] head;
  logic [PTR_W-1:0] commit;
  logic [PTR_W-1:0] tail;
  logic [CNT_W-1:0] count;
  logic [CNT_W-1:0] com_cnt;

  logic [CNT_W-1:0] pop_n;
  logic [CNT_W-1:0] enq_n;
  logic [PTR_W-1:0] commit_nx;
  logic [PTR_W-1:0] tail_nx;
  logic [CNT_W-1:0] count_nx;
  logic [CNT_W-1:0] com_cnt_nx;

  // only committed entries are offered to the port
  assign drain_en[0] = com_cnt != '0;
  assign drain_en[1] = com_cnt > CNT_W'(1);
  assign drain0 = mem[head];
  assign drain1 = mem[head + PTR_W'(1)];

  always_comb begin
    pop_n = '0;
    if (!hold) begin
      pop_n = CNT_W'(drain_en[0]) + CNT_W'(drain_en[1]);
    end
    enq_n = CNT_W'(enq0_en) + CNT_W'(enq1_en);
    commit_nx = commit + PTR_W'(ret_cnt);
    com_cnt_nx = com_cnt - pop_n + CNT_W'(ret_cnt);
    if (except) begin
      // drop everything past the commit point, incl. this cycle's enqueues
      tail_nx = commit_nx;
      count_nx = com_cnt_nx;
    end else begin
      tail_nx = tail + PTR_W'(enq_n);
      count_nx = count - pop_n + enq_n;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      head <= '0;
      commit <= '0;
      tail <= '0;
      count <= '0;
      com_cnt <= '0;
      stq_stall <= 1'b0;
    end else begin
      head <= head + PTR_W'(pop_n);
      commit <= commit_nx;
      tail <= tail_nx;
      count <= count_nx;
      com_cnt <= com_cnt_nx;
      // free entries after this update below margin
      stq_stall <= count_nx > CNT_W'(STALL_LVL);
    end
  end

  // lane 0 is older, lane 1 follows it
  always_ff @(posedge clk) begin
    if (!except) begin
      if (enq0_en) begin
        mem[tail] <= enq0;
      end
      if (enq1_en) begin
        mem[tail + PTR_W'(enq0_en)] <= enq1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== design/byte_enable_gen.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "lsq_defs.svh"

module byte_enable_gen (
  input  logic [`BANK_W-1:0]         bank,
  input  logic [`LOW_W-1:0]          low,
  input  mem_access_pkg::access_sz_e sz,
  output logic [`BANK_W-1:0]         bank1,
  output logic [`BEN_W-1:0]          bgn_ben,
  output logic [`BEN_W-1:0]          end_ben
);

  localparam int BANK_W = `BANK_W;
  localparam int LOW_W = `LOW_W;

  logic [5:0]        last;
  logic [`BEN_W-1:0] from_low;
  logic [`BEN_W-1:0] to_last;

  always_comb begin
    // offset of the last byte, counted from byte 0 of the begin bank
    last = {4'b0, low} + (6'd1 << sz) - 6'd1;
    bank1 = bank + BANK_W'(last >> LOW_W);
    from_low = {`BEN_W{1'b1}} << low;
    to_last = {`BEN_W{1'b1}} >> (LOW_W'(`BEN_W - 1) - last[`LOW_W-1:0]);
    if (last[5:`LOW_W] == '0) begin
      // fits in one bank
      bgn_ben = from_low & to_last;
      end_ben = from_low & to_last;
    end else begin
      bgn_ben = from_low;
      end_ben = to_last;
    end
  end

endmodule

`default_nettype wire

// ==== design/store_data_align.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "lsq_defs.svh"

module store_data_align (
  input  logic [`SDATA_W-1:0]        data,
  input  logic [`LOW_W-1:0]          low,
  input  mem_access_pkg::access_sz_e sz,
  output logic [`WDATA_W-1:0]        odata
);

  localparam int WDATA_W = `WDATA_W;

  logic [`SDATA_W-1:0] keep;
  logic [`SDATA_W-1:0] masked;

  always_comb begin
    // 16-byte store shifts the mask out entirely, keeping all bits
    keep = ~({`SDATA_W{1'b1}} << (8'd8 << sz));
    masked = data & keep;
    // window starts at byte 0 of the begin bank
    odata = WDATA_W'(masked) << {low, 3'b000};
  end

endmodule

`default_nettype wire

// ==== design/store_write_port.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "lsq_defs.svh"

module store_write_port (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     bus_hold,
  input  logic                     miss_hold,
  input  logic                     miss_pause,
  input  logic                     insert_hold,
  input  store_port_pkg::st_req_t  drain0,
  input  store_port_pkg::st_req_t  drain1,
  input  logic [1:0]               drain_en,
  output logic                     hold,
  output store_port_pkg::st_wreq_t st0,
  output store_port_pkg::st_wreq_t st1
);

  store_port_pkg::st_stage_t [1:0] stage;
  store_port_pkg::st_req_t [1:0]   drain;
  store_port_pkg::st_wreq_t        wreq [2];

  assign hold = bus_hold | miss_hold | miss_pause | insert_hold;

  assign drain[0] = drain0;
  assign drain[1] = drain1;

  // on hold keep the request but drop the enables
  always_ff @(posedge clk) begin
    if (rst) begin
      stage <= '0;
    end else if (!hold) begin
      for (int i = 0; i < 2; i++) begin
        stage[i].en <= drain_en[i];
        stage[i].req <= drain[i];
      end
    end else begin
      stage[0].en <= 1'b0;
      stage[1].en <= 1'b0;
    end
  end

  for (genvar i = 0; i < 2; i++) begin : g_lane
    logic [`BANK_W-1:0]  bank1;
    logic [`BEN_W-1:0]   bgn_ben;
    logic [`BEN_W-1:0]   end_ben;
    logic [`WDATA_W-1:0] odata;

    byte_enable_gen u_ben (
      .bank    (stage[i].req.addr.f.bank),
      .low     (stage[i].req.addr.f.low),
      .sz      (stage[i].req.sz),
      .bank1   (bank1),
      .bgn_ben (bgn_ben),
      .end_ben (end_ben)
    );

    store_data_align u_align (
      .data  (stage[i].req.data),
      .low   (stage[i].req.addr.f.low),
      .sz    (stage[i].req.sz),
      .odata (odata)
    );

    always_comb begin
      wreq[i].en = stage[i].en;
      wreq[i].adata = stage[i].req.addr;
      wreq[i].sz = stage[i].req.sz;
      wreq[i].bank1 = bank1;
      wreq[i].bgn_ben = bgn_ben;
      wreq[i].end_ben = end_ben;
      wreq[i].data = odata;
    end
  end

  assign st0 = wreq[0];
  assign st1 = wreq[1];

endmodule

`default_nettype wire

// ==== design/lsq_store_path.sv ====
`default_nettype none
`timescale 1ns/1ps

module lsq_store_path (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     except,
  input  store_port_pkg::st_req_t  enq0,
  input  store_port_pkg::st_req_t  enq1,
  input  logic                     enq0_en,
  input  logic                     enq1_en,
  input  logic [1:0]               ret_cnt,
  input  logic                     bus_hold,
  input  logic                     miss_hold,
  input  logic                     miss_pause,
  input  logic                     insert_hold,
  output store_port_pkg::st_wreq_t st0,
  output store_port_pkg::st_wreq_t st1,
  output logic                     stq_stall
);

  store_port_pkg::st_req_t drain0;
  store_port_pkg::st_req_t drain1;
  logic [1:0]              drain_en;
  logic                    hold;

  store_queue u_stq (
    .clk       (clk),
    .rst       (rst),
    .except    (except),
    .enq0      (enq0),
    .enq1      (enq1),
    .enq0_en   (enq0_en),
    .enq1_en   (enq1_en),
    .ret_cnt   (ret_cnt),
    .hold      (hold),
    .drain0    (drain0),
    .drain1    (drain1),
    .drain_en  (drain_en),
    .stq_stall (stq_stall)
  );

  // registered write requests toward the data cache
  store_write_port u_wport (
    .clk         (clk),
    .rst         (rst),
    .bus_hold    (bus_hold),
    .miss_hold   (miss_hold),
    .miss_pause  (miss_pause),
    .insert_hold (insert_hold),
    .drain0      (drain0),
    .drain1      (drain1),
    .drain_en    (drain_en),
    .hold        (hold),
    .st0         (st0),
    .st1         (st1)
  );

endmodule

`default_nettype wire

// ==== test/lsq_store_path_asserts.sv ====
`default_nettype none
`timescale 1ns/1ps

module lsq_store_path_asserts (
  input logic                     clk,
  input logic                     rst,
  input logic                     bus_hold,
  input logic                     miss_hold,
  input logic                     miss_pause,
  input logic                     insert_hold,
  input store_port_pkg::st_wreq_t st0,
  input store_port_pkg::st_wreq_t st1,
  input logic                     stq_stall
);

  logic any_hold;

  assign any_hold = bus_hold | miss_hold | miss_pause | insert_hold;

  lane1_needs_lane0: assert property (@(posedge clk) disable iff (rst) st1.en |-> st0.en)
    else $error("st1.en set without st0.en");

  // held stage drops its enables for one cycle per hold edge
  no_en_after_hold: assert property (
    @(posedge clk) disable iff (rst) any_hold |=> (!st0.en && !st1.en))
    else $error("write request enabled after a hold edge");

  stall_low_after_reset: assert property (@(posedge clk) rst |=> !stq_stall)
    else $error("stq_stall high right after reset");

  ben0_nonzero: assert property (@(posedge clk) disable iff (rst) st0.en |-> st0.bgn_ben != '0)
    else $error("st0 enabled with empty begin byte enables");

  ben1_nonzero: assert property (@(posedge clk) disable iff (rst) st1.en |-> st1.bgn_ben != '0)
    else $error("st1 enabled with empty begin byte enables");

endmodule

bind lsq_store_path lsq_store_path_asserts i_asserts (
  .clk         (clk),
  .rst         (rst),
  .bus_hold    (bus_hold),
  .miss_hold   (miss_hold),
  .miss_pause  (miss_pause),
  .insert_hold (insert_hold),
  .st0         (st0),
  .st1         (st1),
  .stq_stall   (stq_stall)
);

`default_nettype wire

// ==== test/tb_lsq_store_path.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "lsq_defs.svh"

module tb_lsq_store_path;

  localparam int MAX_CYCLES = 2000;
  localparam int BANK_W = `BANK_W;
  localparam int LOW_W = `LOW_W;
  localparam int SZ_W = `SZ_W;

  logic                     clk;
  logic                     rst;
  logic                     except;
  store_port_pkg::st_req_t  enq0;
  store_port_pkg::st_req_t  enq1;
  logic                     enq0_en;
  logic                     enq1_en;
  logic [1:0]               ret_cnt;
  logic                     bus_hold;
  logic                     miss_hold;
  logic                     miss_pause;
  logic                     insert_hold;
  store_port_pkg::st_wreq_t st0;
  store_port_pkg::st_wreq_t st1;
  logic                     stq_stall;

  // enqueued but not retired, then retired and waiting on st0/st1
  store_port_pkg::st_req_t  pend_q[$];
  store_port_pkg::st_wreq_t exp_q[$];
  string                    test_name = "reset";
  int                       cycles = 0;

  lsq_store_path i_dut (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic abort_run(string why);
    $display("%s", why);
    $display("RESULT: FAIL");
    $fatal(1);
  endtask

  task automatic check_value(string what, logic [255:0] exp, logic [255:0] act);
    if (exp !== act) begin
      abort_run($sformatf("FAIL %s %s: expected %0h, actual %0h", test_name, what, exp, act));
    end
  endtask

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      abort_run("timeout: the tests did not finish within the cycle limit");
    end
  end

  // expected write request, byte by byte from the bank layout
  function automatic store_port_pkg::st_wreq_t expect_wreq(store_port_pkg::st_req_t r);
    store_port_pkg::st_wreq_t w;
    int nbytes;
    int low;
    int last;
    nbytes = 1 << int'(r.sz);
    low = int'(r.addr.f.low);
    last = low + nbytes - 1;
    w = '0;
    w.en = 1'b1;
    w.adata = r.addr;
    w.sz = r.sz;
    w.bank1 = BANK_W'((int'(r.addr.f.bank) + last / 4) % 32);
    for (int b = 0; b < 4; b++) begin
      if (last < 4) begin
        w.bgn_ben[b] = (b >= low) && (b <= last);
        w.end_ben[b] = (b >= low) && (b <= last);
      end else begin
        w.bgn_ben[b] = (b >= low);
        w.end_ben[b] = (b <= last % 4);
      end
    end
    for (int i = 0; i < nbytes; i++) begin
      w.data[(low + i) * 8 +: 8] = r.data[i * 8 +: 8];
    end
    return w;
  endfunction

  function automatic store_port_pkg::st_req_t make_store(int sz, int low);
    store_port_pkg::st_req_t r;
    r.addr.word = $urandom;
    r.addr.f.low = LOW_W'(low);
    r.sz = mem_access_pkg::access_sz_e'(SZ_W'(sz));
    r.data = {$urandom, $urandom, $urandom, $urandom};
    return r;
  endfunction

  task automatic compare_lane(string lane, store_port_pkg::st_wreq_t act);
    if (exp_q.size() == 0) begin
      abort_run($sformatf("%s: %s carried a store that was never retired", test_name, lane));
    end else begin
      check_value(lane, 256'(exp_q.pop_front()), 256'(act));
    end
  endtask

  // outputs are stable mid-cycle
  always @(negedge clk) begin
    if (!rst) begin
      if (st0.en) begin
        compare_lane("st0", st0);
      end
      if (st1.en) begin
        compare_lane("st1", st1);
      end
    end
  end

  task automatic tick;
    @(posedge clk);
    enq0_en <= 1'b0;
    enq1_en <= 1'b0;
    ret_cnt <= 2'd0;
    except <= 1'b0;
  endtask

  task automatic enqueue(store_port_pkg::st_req_t a, store_port_pkg::st_req_t b, int n);
    tick();
    enq0 <= a;
    enq0_en <= 1'b1;
    pend_q.push_back(a);
    if (n > 1) begin
      enq1 <= b;
      enq1_en <= 1'b1;
      pend_q.push_back(b);
    end
  endtask

  task automatic retire(int n);
    tick();
    if (pend_q.size() < n) begin
      abort_run("testbench tried to retire more stores than were enqueued");
    end else begin
      ret_cnt <= 2'(n);
      repeat (n) begin
        exp_q.push_back(expect_wreq(pend_q.pop_front()));
      end
    end
  endtask

  task automatic set_hold(int which, logic v);
    case (which)
      0: bus_hold <= v;
      1: miss_hold <= v;
      2: miss_pause <= v;
      default: insert_hold <= v;
    endcase
  endtask

  task automatic step_check_lanes(logic e0, logic e1);
    tick();
    @(negedge clk);
    check_value("st0.en", 256'(e0), 256'(st0.en));
    check_value("st1.en", 256'(e1), 256'(st1.en));
  endtask

  task automatic step_check_stall(logic exp);
    tick();
    @(negedge clk);
    check_value("stq_stall", 256'(exp), 256'(stq_stall));
  endtask

  task automatic wait_drain;
    while (exp_q.size() != 0) begin
      tick();
    end
    // a few idle cycles to catch stray requests
    repeat (4) begin
      tick();
    end
  endtask

  task automatic test_single_sizes;
    store_port_pkg::st_req_t r;
    test_name = "single_sizes";
    for (int sz = 0; sz < 5; sz++) begin
      for (int low = 0; low < 4; low++) begin
        r = make_store(sz, low);
        // wide stores from the last bank wrap to bank 0
        if (sz >= 3) begin
          r.addr.f.bank = BANK_W'(31);
        end
        enqueue(r, r, 1);
        retire(1);
        step_check_lanes(1'b0, 1'b0);
        step_check_lanes(1'b1, 1'b0);
      end
    end
    wait_drain();
  endtask

  task automatic test_dual_retire;
    store_port_pkg::st_req_t s [5];
    test_name = "dual_retire";
    for (int i = 0; i < 5; i++) begin
      s[i] = make_store(i, (i + 1) % 4);
    end
    enqueue(s[2], s[3], 2);
    retire(2);
    step_check_lanes(1'b0, 1'b0);
    step_check_lanes(1'b1, 1'b1);
    wait_drain();
    test_name = "five_retire";
    enqueue(s[0], s[1], 2);
    enqueue(s[2], s[3], 2);
    enqueue(s[4], s[4], 1);
    retire(3);
    retire(2);
    step_check_lanes(1'b1, 1'b1);
    step_check_lanes(1'b1, 1'b1);
    step_check_lanes(1'b1, 1'b0);
    step_check_lanes(1'b0, 1'b0);
    wait_drain();
  endtask

  task automatic test_holds;
    for (int h = 0; h < 4; h++) begin
      test_name = $sformatf("hold_%0d", h);
      enqueue(make_store(h, h), make_store(4, 3 - h), 2);
      set_hold(h, 1'b1);
      enqueue(make_store(3, h), make_store(0, 0), 1);
      retire(2);
      retire(1);
      repeat (6) begin
        step_check_lanes(1'b0, 1'b0);
      end
      tick();
      set_hold(h, 1'b0);
      // held stores leave at the first edge with the hold low
      step_check_lanes(1'b1, 1'b1);
      step_check_lanes(1'b1, 1'b0);
      wait_drain();
    end
  endtask

  task automatic test_except;
    store_port_pkg::st_req_t c;
    store_port_pkg::st_req_t d;
    test_name = "except_flush";
    c = make_store(2, 1);
    d = make_store(1, 3);
    enqueue(make_store(4, 2), make_store(3, 1), 2);
    // first store commits while c is enqueued
    retire(1);
    enq0 <= c;
    enq0_en <= 1'b1;
    tick();
    except <= 1'b1;
    enq0 <= d;
    enq0_en <= 1'b1;
    pend_q.delete();
    wait_drain();
    test_name = "after_except";
    enqueue(make_store(0, 2), make_store(2, 0), 2);
    retire(2);
    wait_drain();
  endtask

  task automatic test_fill_stall;
    test_name = "fill_stall";
    for (int p = 0; p < 6; p++) begin
      enqueue(make_store(p % 5, p % 4), make_store((p + 2) % 5, (p + 1) % 4), 2);
    end
    // 12 used, 4 free
    step_check_stall(1'b0);
    enqueue(make_store(4, 1), make_store(1, 2), 1);
    // 13 used, 3 free
    step_check_stall(1'b1);
    repeat (4) begin
      retire(3);
    end
    retire(1);
    wait_drain();
    step_check_stall(1'b0);
  endtask

  initial begin
    void'($urandom(32'h4fdaf6dd));
    rst = 1'b1;
    except = 1'b0;
    enq0 = '0;
    enq1 = '0;
    enq0_en = 1'b0;
    enq1_en = 1'b0;
    ret_cnt = 2'd0;
    bus_hold = 1'b0;
    miss_hold = 1'b0;
    miss_pause = 1'b0;
    insert_hold = 1'b0;
    repeat (4) begin
      @(posedge clk);
    end
    rst <= 1'b0;
    test_single_sizes();
    test_dual_retire();
    test_holds();
    test_except();
    test_fill_stall();
    if (exp_q.size() != 0 || pend_q.size() != 0) begin
      abort_run("stores were left over at the end of the run");
    end else begin
      $display("RESULT: PASS");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== lsq_store_path.f ====
+incdir+design
design/mem_access_pkg.sv
design/store_port_pkg.sv
design/store_queue.sv
design/byte_enable_gen.sv
design/store_data_align.sv
design/store_write_port.sv
design/lsq_store_path.sv
test/lsq_store_path_asserts.sv
test/tb_lsq_store_path.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the store path testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module tb_lsq_store_path \
  -f lsq_store_path.f \
  -o sim_tb

./obj_dir/sim_tb
